// File: dv/enc_dec_tests.txt
# columns: name, select (hex), input word (hex), expected output word (hex)
# expected words follow the decode, encode, round trip and normalize rules
# decode lane
dec_zero 0 00000000000000000000000000000000 11111111111111111111111111111111
dec_ones 0 FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF 88888888888888888888888888888888
dec_alt5 0 55555555555555555555555555555555 22222222222222222222222222222222
dec_altA 0 AAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAA 44444444444444444444444444444444
dec_group0 0 00000000000000000000000000000003 11111111111111111111111111111118
dec_group31 0 FFFFFFFFFFFFFFFFC000000000000000 81111111111111111111111111111111
dec_count 0 000000000000000000123456789ABCDEF 11121418212224284142444881828488
dec_mixed 0 DEADBEEFDEADBEEFFEDCBA9876543210 88848281484442412824222118141211
# encode lane
enc_zero 1 00000000000000000000000000000000 00000000000000000000000000000000
enc_ones 1 FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF 0000000000000000FFFFFFFFFFFFFFFF
enc_onehot 1 84218421842184218421842184218421 0000000000000000E4E4E4E4E4E4E4E4
enc_count 1 0123456789ABCDEF0123456789ABCDEF 000000000000000005AAFFFF05AAFFFF
enc_mixed 1 3C00F0E17B2A06900000000013579BDF 000000000000000070CCB72C00001AFF
enc_bit0 1 11111111111111111111111111111111 00000000000000000000000000000000
enc_pairs 1 22223333666677770000000000000000 00000000000000005555AAAA00000000
# round trip lane
rt_zero 2 00000000000000000000000000000000 00000000000000000000000000000000
rt_ones 2 FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF 0000000000000000FFFFFFFFFFFFFFFF
rt_count 2 FEDCBA98765432100123456789ABCDEF 00000000000000000123456789ABCDEF
rt_mixed 2 A5A5A5A5A5A5A5A5DEADBEEFCAFEF00D 0000000000000000DEADBEEFCAFEF00D
rt_sparse 2 FFFFFFFF000000008000000000000001 00000000000000008000000000000001
# normalize lane
nrm_zero 3 00000000000000000000000000000000 11111111111111111111111111111111
nrm_ones 3 FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF 88888888888888888888888888888888
nrm_count 3 0123456789ABCDEF0123456789ABCDEF 11224444888888881122444488888888
nrm_mixed 3 3C00F0E17B2A06900000000013579BDF 28118181482814811111111112448888
nrm_onehot 3 84218421842184218421842184218421 84218421842184218421842184218421
nrm_low 3 11111111222222223333333344444444 11111111222222222222222244444444
# lane switching, select changes on every vector
sw_dec_a 0 0000000000000000FFFFFFFF00000000 88888888888888881111111111111111
sw_enc_a 1 00000000FFFFFFFF1111111188888888 00000000000000000000FFFF0000FFFF
sw_nrm_a 3 C0000000000000000000000000000003 81111111111111111111111111111112
sw_rt_a 2 0000000000000000123456789ABCDEF0 0000000000000000123456789ABCDEF0
sw_dec_b 0 000000000000000055555555AAAAAAAA 22222222222222224444444444444444
sw_nrm_b 3 77777777777777777777777777777777 44444444444444444444444444444444
sw_enc_b 1 44444444444444444444444444444444 0000000000000000AAAAAAAAAAAAAAAA
sw_rt_b 2 FFFFFFFFFFFFFFFF0000000000000000 00000000000000000000000000000000
sw_dec_c 0 FFFFFFFFFFFFFFFF0000000000000000 11111111111111111111111111111111
sw_enc_c 1 FFFFFFFFFFFFFFFF0000000000000000 0000000000000000FFFFFFFF00000000

// File: tb.f
+incdir+source
source/enc_dec_pkg.sv
source/dec_2x4_bank.sv
source/enc_4x2_bank.sv
source/multi_enc_decx2x4.sv
source/wrapper_multi_enc_decx2x4.sv
dv/enc_dec_asserts.sv
dv/tb_wrapper.sv

// File: run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_wrapper -f tb.f -o tb_wrapper_sim

./obj_dir/tb_wrapper_sim > sim.log 2>&1
cat sim.log

if grep -q "sim failed" sim.log; then
    echo "simulation reported failure, see sim.log"
    exit 1
fi

grep -q "sim passed" sim.log

// File: dv/tb_wrapper.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the four-lane wrapper, vectors come from the tests file.
// each vector sets select and input, holds, then checks the output word.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

`include "enc_dec_settings.svh"

module tb_wrapper
    import enc_dec_pkg::*;
();

    localparam int    CLK_HALF   = 5;   // 10 ns period.
    localparam int    RST_CYCLES = 3;
    localparam int    HOLD_EDGES = 3;   // chained lanes need two, one spare.
    localparam int    MAX_LINES  = 256; // bound on the file loop.
    localparam string TEST_FILE  = "dv/enc_dec_tests.txt";

    logic  clock;
    logic  rst;
    data_t datain_temp;
    sel_t  select_datain_temp;
    data_t dataout_temp;

    int errors;  // wrong values plus file problems.
    int checks;  // compares done.
    int vectors; // vectors applied from the file.

    wrapper_multi_enc_decx2x4 u_dut (
        .clock              (clock),
        .rst                (rst),
        .datain_temp        (datain_temp),
        .select_datain_temp (select_datain_temp),
        .dataout_temp       (dataout_temp)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #CLK_HALF clock = ~clock;
        end
    end

    // one compare of the output against a hand-derived value.
    task automatic compare_output(input string name, input data_t expected);
        checks++;
        if (dataout_temp !== expected) begin
            errors++;
            $display("ERR %0s expected %h actual %h", name, expected, dataout_temp);
        end
    endtask

    // counted hold, inputs stay put across it.
    task automatic hold_edges(input int count);
        for (int i = 0; i < count; i++) begin
            @(posedge clock);
        end
    endtask

    // called on a falling edge, returns on a falling edge.
    task automatic apply_vector(input string name, input sel_t sel,
                                input data_t din, input data_t expected);
        select_datain_temp = sel;
        datain_temp        = din;
        hold_edges(HOLD_EDGES);
        @(negedge clock); // sample midway between edges.
        compare_output(name, expected);
    endtask

    // reset for three edges, output must read zero throughout.
    task automatic reset_dut();
        rst                = 1'b1;
        select_datain_temp = '0;
        datain_temp        = '0;
        @(posedge clock);
        @(negedge clock);
        compare_output("reset_during", '0);
        hold_edges(RST_CYCLES - 1);
        @(negedge clock);
        rst = 1'b0;
        compare_output("reset_release", '0); // banks still hold reset value.
    endtask

    initial begin
        int              fd;
        int              line_no;
        int              fields;
        int              sel_val;
        string           line;
        string           name;
        logic [8*32-1:0] name_buf;
        data_t           din;
        data_t           expected;

        errors  = 0;
        checks  = 0;
        vectors = 0;
        line_no = 0;
        reset_dut();

        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            errors++;
            $display("could not open test file %0s", TEST_FILE);
        end else begin
            while (line_no < MAX_LINES && $fgets(line, fd) != 0) begin
                line_no++;
                // blank lines and comments.
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                fields = $sscanf(line, "%s %h %h %h", name_buf, sel_val, din, expected);
                name   = $sformatf("%0s", name_buf);
                if (fields != 4) begin
                    errors++;
                    $display("malformed line %0d in test file", line_no);
                end else if (sel_val < 0 || sel_val >= `NUM_LANES) begin
                    errors++;
                    $display("select %0d out of range on line %0d", sel_val, line_no);
                end else begin
                    vectors++;
                    apply_vector(name, sel_t'(sel_val), din, expected);
                end
            end
            if (line_no >= MAX_LINES) begin
                errors++;
                $display("test file longer than %0d lines, stopped reading", MAX_LINES);
            end
            $fclose(fd);
        end

        if (vectors == 0) begin
            errors++;
            $display("no test vectors were applied");
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: dv/enc_dec_asserts.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lane output properties checked inside the core.
// attached to every core instance by the bind at the end.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module enc_dec_asserts
    import enc_dec_pkg::*;
(
    input logic         clock,
    input logic         rst,
    input lane_bundle_t lanes_in,
    input lane_bundle_t lanes_out
);

    // every nibble of the word has exactly one bit set.
    function automatic bit nibbles_onehot(input data_t word);
        logic [3:0] nib;
        nibbles_onehot = 1'b1;
        for (int g = 0; g < $bits(data_t)/4; g++) begin
            nib = word[4*g +: 4];
            if ($countones(nib) != 1) begin
                nibbles_onehot = 1'b0;
            end
        end
    endfunction

    // decoder outputs once the first edge out of reset has passed.
    lane0_onehot_a: assert property (@(posedge clock)
        (!rst && !$past(rst)) |-> nibbles_onehot(lanes_out.lane0))
        else $error("lane 0 output has a nibble that is not one-hot");

    lane3_onehot_a: assert property (@(posedge clock)
        (!rst && !$past(rst)) |-> nibbles_onehot(lanes_out.lane3))
        else $error("lane 3 output has a nibble that is not one-hot");

    // encoder results are zero-extended.
    upper_zero_a: assert property (@(posedge clock) disable iff (rst)
        (lanes_out.lane1 >> $bits(half_t)) == '0 && (lanes_out.lane2 >> $bits(half_t)) == '0)
        else $error("upper half of lane 1 or lane 2 output is nonzero");

    // lane 2 gives back the low input half two edges later.
    lane2_round_trip_a: assert property (@(posedge clock)
        (!$past(rst) && !$past(rst, 2)) |->
            lanes_out.lane2 == data_t'($past(half_t'(lanes_in.lane2), 2)))
        else $error("lane 2 output differs from its input two cycles earlier");

    after_reset_a: assert property (@(posedge clock)
        $past(rst) |-> lanes_out == '0)
        else $error("core output nonzero in the cycle after reset");

endmodule

bind multi_enc_decx2x4 enc_dec_asserts u_asserts (
    .clock     (clock),
    .rst       (rst),
    .lanes_in  (lanes_in),
    .lanes_out (lanes_out)
);

// File: source/wrapper_multi_enc_decx2x4.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// top level that steers the input word to the selected lane of the core
// and returns that lane's registered result, with no added latency.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module wrapper_multi_enc_decx2x4
    import enc_dec_pkg::*;
(
    input  logic  clock,
    input  logic  rst,
    input  data_t datain_temp,        // word for the selected lane.
    input  sel_t  select_datain_temp, // lane select.
    output data_t dataout_temp        // selected lane result.
);

    lane_bundle_t lanes_in;  // only the selected field is live.
    lane_bundle_t lanes_out; // all lane results from the core.

    // idle lanes see zero, output follows select in the same cycle.
    always_comb begin
        lanes_in     = '0;
        dataout_temp = '0;
        case (select_datain_temp)
            2'd0: begin
                lanes_in.lane0 = datain_temp;
                dataout_temp   = lanes_out.lane0; // decode.
            end
            2'd1: begin
                lanes_in.lane1 = datain_temp;
                dataout_temp   = lanes_out.lane1; // encode.
            end
            2'd2: begin
                lanes_in.lane2 = datain_temp;
                dataout_temp   = lanes_out.lane2; // round trip.
            end
            2'd3: begin
                lanes_in.lane3 = datain_temp;
                dataout_temp   = lanes_out.lane3; // normalize.
            end
        endcase
    end

    multi_enc_decx2x4 multi_enc_decx2x4_inst (
        .clock     (clock),
        .rst       (rst),
        .lanes_in  (lanes_in),
        .lanes_out (lanes_out)
    );

endmodule

// File: source/multi_enc_decx2x4.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// four-lane core: decode, encode, decode-encode and encode-decode.
// lanes 0 and 1 take one cycle, the chained lanes 2 and 3 take two.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

`include "enc_dec_settings.svh"

module multi_enc_decx2x4
    import enc_dec_pkg::*;
(
    input  logic         clock,
    input  logic         rst,
    input  lane_bundle_t lanes_in,  // one word per lane.
    output lane_bundle_t lanes_out  // registered lane results.
);

    localparam int GROUPS = `DATA_W/4; // nibbles per lane word.

    data_t lane0_onehot; // lane 0 decoder result.
    half_t lane1_code;   // lane 1 encoder result.
    data_t lane2_onehot; // lane 2 first stage.
    half_t lane2_code;   // lane 2 second stage, low input bits again.
    half_t lane3_code;   // lane 3 first stage.
    data_t lane3_onehot; // lane 3 second stage, normalized nibbles.

    // lane 0, decode the low half of the input.
    dec_2x4_bank #(.GROUPS(GROUPS)) u_lane0_dec (
        .clock  (clock),
        .rst    (rst),
        .code   (half_t'(lanes_in.lane0)), // upper half dropped.
        .onehot (lane0_onehot)
    );

    // lane 1, encode the full word.
    enc_4x2_bank #(.GROUPS(GROUPS)) u_lane1_enc (
        .clock (clock),
        .rst   (rst),
        .lines (lanes_in.lane1),
        .code  (lane1_code)
    );

    // lane 2, decode then encode.
    dec_2x4_bank #(.GROUPS(GROUPS)) u_lane2_dec (
        .clock  (clock),
        .rst    (rst),
        .code   (half_t'(lanes_in.lane2)),
        .onehot (lane2_onehot)
    );

    enc_4x2_bank #(.GROUPS(GROUPS)) u_lane2_enc (
        .clock (clock),
        .rst   (rst),
        .lines (lane2_onehot), // every nibble one-hot here.
        .code  (lane2_code)
    );

    // lane 3, encode then decode.
    enc_4x2_bank #(.GROUPS(GROUPS)) u_lane3_enc (
        .clock (clock),
        .rst   (rst),
        .lines (lanes_in.lane3),
        .code  (lane3_code)
    );

    dec_2x4_bank #(.GROUPS(GROUPS)) u_lane3_dec (
        .clock  (clock),
        .rst    (rst),
        .code   (lane3_code),
        .onehot (lane3_onehot) // zero code gives 0001 per nibble.
    );

    // encoder results zero-extended to lane width.
    always_comb begin
        lanes_out.lane0 = lane0_onehot;
        lanes_out.lane1 = data_t'(lane1_code);
        lanes_out.lane2 = data_t'(lane2_code);
        lanes_out.lane3 = lane3_onehot;
    end

endmodule

// File: source/enc_4x2_bank.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// registered bank of 4-to-2 priority encoders, highest set bit wins.
// one cycle of latency; an empty nibble encodes as zero.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

`include "enc_dec_settings.svh"

module enc_4x2_bank
    import enc_dec_pkg::*;
#(
    parameter int GROUPS = `DATA_W/4 // nibbles encoded.
) (
    input  logic  clock,
    input  logic  rst,
    input  data_t lines, // 4 request lines per group.
    output half_t code   // index of highest line per group.
);

    half_t code_d;    // encoded word before the register.
    logic [3:0] nib;  // current nibble under test.

    // top bit has priority, so one-hot nibbles come back exactly.
    always_comb begin
        code_d = '0;
        nib    = '0;
        for (int g = 0; g < GROUPS; g++) begin
            nib = lines[4*g +: 4];
            if (nib[3]) begin
                code_d[2*g +: 2] = 2'd3;
            end else if (nib[2]) begin
                code_d[2*g +: 2] = 2'd2;
            end else if (nib[1]) begin
                code_d[2*g +: 2] = 2'd1;
            end else begin
                code_d[2*g +: 2] = 2'd0; // bit 0 alone or nothing set.
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            code <= '0;
        end else begin
            code <= code_d;
        end
    end

endmodule

// File: source/dec_2x4_bank.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// registered bank of 2-to-4 decoders, one one-hot nibble per 2-bit code.
// one cycle of latency; reset clears the output register.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

`include "enc_dec_settings.svh"

module dec_2x4_bank
    import enc_dec_pkg::*;
#(
    parameter int GROUPS = `DATA_W/4 // code groups, one per output nibble.
) (
    input  logic  clock,
    input  logic  rst,
    input  half_t code,   // 2 bits per group.
    output data_t onehot  // 4 bits per group.
);

    data_t onehot_d; // decoded word before the register.

    // group g with value v lights bit v of nibble g.
    always_comb begin
        onehot_d = '0;
        for (int g = 0; g < GROUPS; g++) begin
            onehot_d[4*g +: 4] = 4'b0001 << code[2*g +: 2];
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            onehot <= '0;
        end else begin
            onehot <= onehot_d; // single register stage.
        end
    end

endmodule

// File: source/enc_dec_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types for the encoder/decoder lanes and the wrapper.
// compile first; modules pull it in with a wildcard import.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "enc_dec_settings.svh"

package enc_dec_pkg;

    typedef logic [`DATA_W-1:0]            data_t; // full lane word.
    typedef logic [`DATA_W/2-1:0]          half_t; // encoded word, 2 bits per nibble.
    typedef logic [$clog2(`NUM_LANES)-1:0] sel_t;  // lane select.

    // one word per lane, lane3 in the top bits.
    typedef struct packed {
        data_t lane3; // encode then decode.
        data_t lane2; // decode then encode.
        data_t lane1; // encode only.
        data_t lane0; // decode only.
    } lane_bundle_t;

endpackage

// File: source/enc_dec_settings.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sizing macros for the four-lane encoder/decoder subsystem.
// include before the package or any module that sizes from them.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef ENC_DEC_SETTINGS_SVH
`define ENC_DEC_SETTINGS_SVH

`define DATA_W    128 // full lane word, 32 nibbles.
`define NUM_LANES 4   // decode, encode, round trip, normalize.

`endif
